// ==== common/eth_switch_macros.svh ====
`ifndef ETH_SWITCH_MACROS_SVH
`define ETH_SWITCH_MACROS_SVH

// Stream beat layout
`define ETH_DATA_W  64
`define ETH_USER_W  4
`define ETH_ERR_BIT 3

// Register port
`define REG_AWIDTH 14
`define REG_DWIDTH 32

// Register map
`define ADDR_MAC_LSB        14'h0000
`define ADDR_MAC_MSB        14'h0004
`define ADDR_IP             14'h1000
`define ADDR_UDP            14'h1004
`define ADDR_BRIDGE_MAC_LSB 14'h1010
`define ADDR_BRIDGE_MAC_MSB 14'h1014
`define ADDR_BRIDGE_IP      14'h1018
`define ADDR_BRIDGE_UDP     14'h101C
`define ADDR_BRIDGE_ENABLE  14'h1020

// Gate memory holds 2**GATE_AW beats
`define GATE_AW 6

// Reset identity: 00:80:2f:16:c5:2f, 192.168.10.2, ports 49154/49153
`define DEFAULT_MAC 48'h0080_2F16_C52F
`define DEFAULT_IP  32'hC0A8_0A02
`define DEFAULT_UDP {16'd49154, 16'd49153}
`define BCAST_MAC   48'hFFFF_FFFF_FFFF

`endif

// ==== common/eth_stream_pkg.sv ====
`include "eth_switch_macros.svh"

package eth_stream_pkg;

  ////////////////////////////////
  // Stream beat
  ////////////////////////////////

  // One 64-bit word of a packet, user bit 3 flags a MAC error
  typedef struct packed {
    logic                   last;
    logic [`ETH_USER_W-1:0] user;
    logic [`ETH_DATA_W-1:0] data;
  } axis_beat_t;

  ////////////////////////////////
  // Routing decision
  ////////////////////////////////

  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_VITA = 2'd1,
    DEST_CPU  = 2'd2,
    DEST_DROP = 2'd3
  } dest_e;

endpackage

// ==== common/eth_regs_pkg.sv ====
`include "eth_switch_macros.svh"

package eth_regs_pkg;

  ////////////////////////////////
  // Register map
  ////////////////////////////////

  typedef enum logic [`REG_AWIDTH-1:0] {
    REG_MAC_LSB        = `ADDR_MAC_LSB,
    REG_MAC_MSB        = `ADDR_MAC_MSB,
    REG_IP             = `ADDR_IP,
    REG_UDP            = `ADDR_UDP,
    REG_BRIDGE_MAC_LSB = `ADDR_BRIDGE_MAC_LSB,
    REG_BRIDGE_MAC_MSB = `ADDR_BRIDGE_MAC_MSB,
    REG_BRIDGE_IP      = `ADDR_BRIDGE_IP,
    REG_BRIDGE_UDP     = `ADDR_BRIDGE_UDP,
    REG_BRIDGE_ENABLE  = `ADDR_BRIDGE_ENABLE
  } reg_addr_e;

  // Identity the dispatcher matches against
  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port0;
    logic [15:0] port1;
  } dev_addr_t;

endpackage

// ==== hdl/switch_regs.sv ====
`timescale 1ns/10ps
`include "eth_switch_macros.svh"

module switch_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    i_reg_wr_req,
  input  logic [`REG_AWIDTH-1:0]  i_reg_wr_addr,
  input  logic [`REG_DWIDTH-1:0]  i_reg_wr_data,
  input  logic                    i_reg_rd_req,
  input  logic [`REG_AWIDTH-1:0]  i_reg_rd_addr,
  output logic                    o_reg_rd_resp,
  output logic [`REG_DWIDTH-1:0]  o_reg_rd_data,
  output eth_regs_pkg::dev_addr_t o_dev_addr
);

  eth_regs_pkg::dev_addr_t norm_addr;
  eth_regs_pkg::dev_addr_t bridge_addr;
  logic                    bridge_en;
  logic                    rd_hit;
  logic [`REG_DWIDTH-1:0]  rd_mux;

  ////////////////////////////////
  // Write decode
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      norm_addr.mac                         <= `DEFAULT_MAC;
      norm_addr.ip                          <= `DEFAULT_IP;
      {norm_addr.port1, norm_addr.port0}     <= `DEFAULT_UDP;
      bridge_addr.mac                       <= `DEFAULT_MAC;
      bridge_addr.ip                        <= `DEFAULT_IP;
      {bridge_addr.port1, bridge_addr.port0} <= `DEFAULT_UDP;
      bridge_en                             <= 1'b0;
    end else if (i_reg_wr_req) begin
      case (i_reg_wr_addr)
        eth_regs_pkg::REG_MAC_LSB:        norm_addr.mac[31:0]    <= i_reg_wr_data;
        eth_regs_pkg::REG_MAC_MSB:        norm_addr.mac[47:32]   <= i_reg_wr_data[15:0];
        eth_regs_pkg::REG_IP:             norm_addr.ip           <= i_reg_wr_data;
        eth_regs_pkg::REG_UDP:
          {norm_addr.port1, norm_addr.port0} <= i_reg_wr_data;
        eth_regs_pkg::REG_BRIDGE_MAC_LSB: bridge_addr.mac[31:0]  <= i_reg_wr_data;
        eth_regs_pkg::REG_BRIDGE_MAC_MSB: bridge_addr.mac[47:32] <= i_reg_wr_data[15:0];
        eth_regs_pkg::REG_BRIDGE_IP:      bridge_addr.ip         <= i_reg_wr_data;
        eth_regs_pkg::REG_BRIDGE_UDP:
          {bridge_addr.port1, bridge_addr.port0} <= i_reg_wr_data;
        eth_regs_pkg::REG_BRIDGE_ENABLE:  bridge_en              <= i_reg_wr_data[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////
  // Read back
  ////////////////////////////////

  always_comb begin
    rd_hit = 1'b1;
    rd_mux = '0;
    case (i_reg_rd_addr)
      eth_regs_pkg::REG_MAC_LSB:        rd_mux = norm_addr.mac[31:0];
      eth_regs_pkg::REG_MAC_MSB:        rd_mux = {16'b0, norm_addr.mac[47:32]};
      eth_regs_pkg::REG_IP:             rd_mux = norm_addr.ip;
      eth_regs_pkg::REG_UDP:            rd_mux = {norm_addr.port1, norm_addr.port0};
      eth_regs_pkg::REG_BRIDGE_MAC_LSB: rd_mux = bridge_addr.mac[31:0];
      eth_regs_pkg::REG_BRIDGE_MAC_MSB: rd_mux = {16'b0, bridge_addr.mac[47:32]};
      eth_regs_pkg::REG_BRIDGE_IP:      rd_mux = bridge_addr.ip;
      eth_regs_pkg::REG_BRIDGE_UDP:     rd_mux = {bridge_addr.port1, bridge_addr.port0};
      eth_regs_pkg::REG_BRIDGE_ENABLE:  rd_mux = {31'b0, bridge_en};
      // Unknown address gets no response
      default:                          rd_hit = 1'b0;
    endcase
  end

  // Response pulses one cycle after each request to a known address
  always_ff @(posedge clk) begin
    if (reset) begin
      o_reg_rd_resp <= 1'b0;
    end else begin
      o_reg_rd_resp <= i_reg_rd_req & rd_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reg_rd_req) begin
      o_reg_rd_data <= rd_mux;
    end
  end

  // Bridge mode swaps in the whole bridge identity
  assign o_dev_addr = bridge_en ? bridge_addr : norm_addr;

endmodule

// ==== packet_gate/packet_gate.sv ====
`timescale 1ns/10ps
`include "eth_switch_macros.svh"

module packet_gate (
  input  logic                       clk,
  input  logic                       reset,
  input  eth_stream_pkg::axis_beat_t i_rx_beat,
  input  logic                       i_rx_valid,
  output logic                       o_rx_ready,
  output eth_stream_pkg::axis_beat_t o_gate_beat,
  output logic                       o_gate_valid,
  input  logic                       i_gate_ready
);

  eth_stream_pkg::axis_beat_t mem [(1 << `GATE_AW)];
  eth_stream_pkg::axis_beat_t rd_beat;

  // Pointers carry one wrap bit above the address
  logic [`GATE_AW:0] wr_ptr;
  logic [`GATE_AW:0] commit_ptr;
  logic [`GATE_AW:0] rd_ptr;
  logic [`GATE_AW:0] pkt_cnt;
  logic              err_seen;
  logic              mem_full;
  logic              wr_en;
  logic              beat_err;
  logic              pkt_commit;
  logic              rd_en;
  logic              pkt_fetched;

  ////////////////////////////////
  // Write side
  ////////////////////////////////

  assign mem_full = (wr_ptr[`GATE_AW] != rd_ptr[`GATE_AW]) &&
                    (wr_ptr[`GATE_AW-1:0] == rd_ptr[`GATE_AW-1:0]);
  assign o_rx_ready = ~mem_full;
  assign wr_en      = i_rx_valid & o_rx_ready;
  assign beat_err   = i_rx_beat.user[`ETH_ERR_BIT];
  assign pkt_commit = wr_en & i_rx_beat.last & ~(err_seen | beat_err);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[`GATE_AW-1:0]] <= i_rx_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      err_seen   <= 1'b0;
    end else if (wr_en) begin
      if (i_rx_beat.last) begin
        err_seen <= 1'b0;
        if (err_seen | beat_err) begin
          // Bad packet, forget everything since the last commit
          wr_ptr <= commit_ptr;
        end else begin
          wr_ptr     <= wr_ptr + 1'b1;
          commit_ptr <= wr_ptr + 1'b1;
        end
      end else begin
        wr_ptr   <= wr_ptr + 1'b1;
        err_seen <= err_seen | beat_err;
      end
    end
  end

  ////////////////////////////////
  // Read side
  ////////////////////////////////

  assign rd_beat     = mem[rd_ptr[`GATE_AW-1:0]];
  // Fetch while a whole packet waits and the output stage can take it
  assign rd_en       = (pkt_cnt != '0) && (~o_gate_valid || i_gate_ready);
  assign pkt_fetched = rd_en & rd_beat.last;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr  <= '0;
      pkt_cnt <= '0;
    end else begin
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({pkt_commit, pkt_fetched})
        2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
        2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
        default: pkt_cnt <= pkt_cnt;
      endcase
    end
  end

  // Output register stage
  always_ff @(posedge clk) begin
    if (reset) begin
      o_gate_valid <= 1'b0;
    end else if (rd_en) begin
      o_gate_valid <= 1'b1;
    end else if (i_gate_ready) begin
      o_gate_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_gate_beat <= rd_beat;
    end
  end

endmodule

// ==== eth_dispatch/eth_dispatch.sv ====
`timescale 1ns/10ps
`include "eth_switch_macros.svh"

module eth_dispatch (
  input  logic                       clk,
  input  logic                       reset,
  input  eth_stream_pkg::axis_beat_t i_gate_beat,
  input  logic                       i_gate_valid,
  output logic                       o_gate_ready,
  input  eth_regs_pkg::dev_addr_t    i_dev_addr,
  output eth_stream_pkg::axis_beat_t o_vita_beat,
  output logic                       o_vita_valid,
  input  logic                       i_vita_ready,
  output eth_stream_pkg::axis_beat_t o_cpu_beat,
  output logic                       o_cpu_valid,
  input  logic                       i_cpu_ready
);

  typedef enum logic [1:0] {
    IDLE,
    HOLD_FIRST,
    ROUTE,
    DRAIN
  } state_e;

  state_e                     state;
  eth_stream_pkg::dest_e      dest;
  eth_stream_pkg::dest_e      hdr_dest;
  eth_stream_pkg::axis_beat_t hold_beat;
  eth_stream_pkg::axis_beat_t out_beat;
  logic [47:0]                dst_mac;
  logic [15:0]                dst_port;
  logic                       mac_own;
  logic                       mac_ok;
  logic                       ip_hit;
  logic                       port_hit;
  logic                       sel_ready;
  logic                       out_active;

  ////////////////////////////////
  // Header match
  ////////////////////////////////

  // In IDLE the first beat is still on the input, later it sits in the hold register
  assign dst_mac  = (state == IDLE) ? i_gate_beat.data[47:0] : hold_beat.data[47:0];
  assign dst_port = i_gate_beat.data[47:32];

  assign mac_own  = (dst_mac == i_dev_addr.mac);
  assign mac_ok   = mac_own | (dst_mac == `BCAST_MAC);
  assign ip_hit   = (i_gate_beat.data[31:0] == i_dev_addr.ip);
  assign port_hit = (dst_port == i_dev_addr.port0) | (dst_port == i_dev_addr.port1);

  // Decision once the second beat is on the input
  always_comb begin
    if (mac_own && ip_hit && port_hit) begin
      hdr_dest = eth_stream_pkg::DEST_VITA;
    end else if (mac_ok) begin
      hdr_dest = eth_stream_pkg::DEST_CPU;
    end else begin
      hdr_dest = eth_stream_pkg::DEST_DROP;
    end
  end

  ////////////////////////////////
  // Control FSM
  ////////////////////////////////

  assign sel_ready = (dest == eth_stream_pkg::DEST_VITA) ? i_vita_ready : i_cpu_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      dest  <= eth_stream_pkg::DEST_NONE;
    end else begin
      case (state)
        IDLE: begin
          if (i_gate_valid) begin
            if (!i_gate_beat.last) begin
              state <= HOLD_FIRST;
            end else if (mac_ok) begin
              // One-beat packet goes by MAC alone
              state <= ROUTE;
              dest  <= eth_stream_pkg::DEST_CPU;
            end
          end
        end
        HOLD_FIRST: begin
          if (i_gate_valid) begin
            dest  <= hdr_dest;
            state <= (hdr_dest == eth_stream_pkg::DEST_DROP) ? DRAIN : ROUTE;
          end
        end
        ROUTE: begin
          if (sel_ready) begin
            if (hold_beat.last) begin
              state <= IDLE;
              dest  <= eth_stream_pkg::DEST_NONE;
            end else begin
              state <= DRAIN;
            end
          end
        end
        DRAIN: begin
          if (i_gate_valid && o_gate_ready && i_gate_beat.last) begin
            state <= IDLE;
            dest  <= eth_stream_pkg::DEST_NONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // First beat waits here until the route is known
  always_ff @(posedge clk) begin
    if (state == IDLE && i_gate_valid) begin
      hold_beat <= i_gate_beat;
    end
  end

  ////////////////////////////////
  // Output steering
  ////////////////////////////////

  always_comb begin
    case (state)
      IDLE:       o_gate_ready = 1'b1;
      DRAIN:      o_gate_ready = (dest == eth_stream_pkg::DEST_DROP) | sel_ready;
      default:    o_gate_ready = 1'b0;
    endcase
  end

  assign out_active = (state == ROUTE) | ((state == DRAIN) & i_gate_valid);
  assign out_beat   = (state == ROUTE) ? hold_beat : i_gate_beat;

  assign o_vita_valid = out_active & (dest == eth_stream_pkg::DEST_VITA);
  assign o_cpu_valid  = out_active & (dest == eth_stream_pkg::DEST_CPU);
  assign o_vita_beat  = out_beat;
  assign o_cpu_beat   = out_beat;

endmodule

// ==== hdl/eth_switch.sv ====
`timescale 1ns/10ps
`include "eth_switch_macros.svh"

module eth_switch (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       i_reg_wr_req,
  input  logic [`REG_AWIDTH-1:0]     i_reg_wr_addr,
  input  logic [`REG_DWIDTH-1:0]     i_reg_wr_data,
  input  logic                       i_reg_rd_req,
  input  logic [`REG_AWIDTH-1:0]     i_reg_rd_addr,
  output logic                       o_reg_rd_resp,
  output logic [`REG_DWIDTH-1:0]     o_reg_rd_data,
  input  eth_stream_pkg::axis_beat_t i_rx_beat,
  input  logic                       i_rx_valid,
  output logic                       o_rx_ready,
  output eth_stream_pkg::axis_beat_t o_vita_beat,
  output logic                       o_vita_valid,
  input  logic                       i_vita_ready,
  output eth_stream_pkg::axis_beat_t o_cpu_beat,
  output logic                       o_cpu_valid,
  input  logic                       i_cpu_ready
);

  eth_regs_pkg::dev_addr_t    dev_addr;
  eth_stream_pkg::axis_beat_t gate_beat;
  logic                       gate_valid;
  logic                       gate_ready;

  ////////////////////////////////
  // Configuration
  ////////////////////////////////

  switch_regs regs0 (
    .clk           (clk),
    .reset         (reset),
    .i_reg_wr_req  (i_reg_wr_req),
    .i_reg_wr_addr (i_reg_wr_addr),
    .i_reg_wr_data (i_reg_wr_data),
    .i_reg_rd_req  (i_reg_rd_req),
    .i_reg_rd_addr (i_reg_rd_addr),
    .o_reg_rd_resp (o_reg_rd_resp),
    .o_reg_rd_data (o_reg_rd_data),
    .o_dev_addr    (dev_addr)
  );

  ////////////////////////////////
  // Receive path
  ////////////////////////////////

  // Whole packets only, errored ones never leave the gate
  packet_gate gate0 (
    .clk          (clk),
    .reset        (reset),
    .i_rx_beat    (i_rx_beat),
    .i_rx_valid   (i_rx_valid),
    .o_rx_ready   (o_rx_ready),
    .o_gate_beat  (gate_beat),
    .o_gate_valid (gate_valid),
    .i_gate_ready (gate_ready)
  );

  eth_dispatch dispatch0 (
    .clk          (clk),
    .reset        (reset),
    .i_gate_beat  (gate_beat),
    .i_gate_valid (gate_valid),
    .o_gate_ready (gate_ready),
    .i_dev_addr   (dev_addr),
    .o_vita_beat  (o_vita_beat),
    .o_vita_valid (o_vita_valid),
    .i_vita_ready (i_vita_ready),
    .o_cpu_beat   (o_cpu_beat),
    .o_cpu_valid  (o_cpu_valid),
    .i_cpu_ready  (i_cpu_ready)
  );

endmodule

// ==== testbench/tb_eth_switch.sv ====
`timescale 1ns/10ps
`include "eth_switch_macros.svh"

module tb_eth_switch;

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       i_reg_wr_req;
  logic [`REG_AWIDTH-1:0]     i_reg_wr_addr;
  logic [`REG_DWIDTH-1:0]     i_reg_wr_data;
  logic                       i_reg_rd_req;
  logic [`REG_AWIDTH-1:0]     i_reg_rd_addr;
  logic                       o_reg_rd_resp;
  logic [`REG_DWIDTH-1:0]     o_reg_rd_data;
  eth_stream_pkg::axis_beat_t i_rx_beat;
  logic                       i_rx_valid;
  logic                       o_rx_ready;
  eth_stream_pkg::axis_beat_t o_vita_beat;
  logic                       o_vita_valid;
  logic                       i_vita_ready = 1'b1;
  eth_stream_pkg::axis_beat_t o_cpu_beat;
  logic                       o_cpu_valid;
  logic                       i_cpu_ready = 1'b1;

  // Expected beats per output, and the test number of each queued packet
  eth_stream_pkg::axis_beat_t vita_q[$];
  eth_stream_pkg::axis_beat_t cpu_q[$];
  int                         vita_ids[$];
  int                         cpu_ids[$];
  int                         drv_errors = 0;
  int                         mon_errors = 0;
  int                         tests = 0;
  int                         cycles = 0;
  int                         limit = 200;
  logic [15:0]                lfsr = 16'd17645;

  eth_switch dut0 (.*);

  always #5 clk = ~clk;

  ////////////////////////////////
  // Random back-pressure
  ////////////////////////////////

  // Galois LFSR, one step per bit handed out
  function automatic logic rand_bit();
    rand_bit = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
  endfunction

  // Each output stalls about one cycle in four
  always @(posedge clk) begin
    if (!reset) begin
      i_vita_ready <= rand_bit() | rand_bit();
      i_cpu_ready  <= rand_bit() | rand_bit();
    end
  end

  ////////////////////////////////
  // Output monitor
  ////////////////////////////////

  task automatic check_beat(input int port, input eth_stream_pkg::axis_beat_t got);
    eth_stream_pkg::axis_beat_t want;
    string name;
    int id;
    name = (port == 0) ? "o_vita_beat" : "o_cpu_beat";
    if ((port == 0 && vita_q.size() == 0) || (port == 1 && cpu_q.size() == 0)) begin
      $display("Unexpected beat %h left on %s at %0t", got.data, name, $time);
      mon_errors++;
    end else begin
      if (port == 0) begin
        want = vita_q.pop_front();
      end else begin
        want = cpu_q.pop_front();
      end
      if (got !== want) begin
        $display("Fail %0t %s expected %h got %h", $time, name, want, got);
        mon_errors++;
      end
      if (want.last) begin
        if (port == 0) begin
          id = vita_ids.pop_front();
        end else begin
          id = cpu_ids.pop_front();
        end
        $display("test %0d: packet complete on %s", id, name);
      end
    end
  endtask

  // Valid and ready are both stable at the falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (!reset && o_vita_valid && i_vita_ready) begin
        check_beat(0, o_vita_beat);
      end
      if (!reset && o_cpu_valid && i_cpu_ready) begin
        check_beat(1, o_cpu_beat);
      end
    end
  end

  initial begin
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d VITA and %0d CPU beats never arrived",
             cycles, vita_q.size(), cpu_q.size());
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////
  // Register port
  ////////////////////////////////

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    i_reg_wr_req  <= 1'b1;
    i_reg_wr_addr <= addr[`REG_AWIDTH-1:0];
    i_reg_wr_data <= data;
    @(posedge clk);
    i_reg_wr_req <= 1'b0;
    $display("test %0d: write %h done", tests, addr);
  endtask

  task automatic reg_read(input logic [31:0] addr, input logic [31:0] want, input bit resp_due);
    bit ok;
    ok = 1'b1;
    @(posedge clk);
    i_reg_rd_req  <= 1'b1;
    i_reg_rd_addr <= addr[`REG_AWIDTH-1:0];
    @(posedge clk);
    i_reg_rd_req <= 1'b0;
    // Response belongs in the cycle right after the request edge
    @(negedge clk);
    if (o_reg_rd_resp !== resp_due) begin
      $display("%s for address %h at %0t",
               resp_due ? "Missing read response" : "Response to unknown address", addr, $time);
      ok = 1'b0;
    end else if (resp_due && o_reg_rd_data !== want) begin
      $display("Fail %0t o_reg_rd_data expected %h got %h", $time, want, o_reg_rd_data);
      ok = 1'b0;
    end
    @(negedge clk);
    if (o_reg_rd_resp !== 1'b0) begin
      $display("Read response lasted more than one cycle at %0t", $time);
      ok = 1'b0;
    end
    @(posedge clk);
    if (!ok) begin
      drv_errors++;
    end
    $display("test %0d: read %h %s", tests, addr, ok ? "ok" : "failed");
  endtask

  // Routing follows the identity at dispatch time, so let packets leave first
  task automatic wait_drained();
    while (vita_q.size() != 0 || cpu_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  ////////////////////////////////
  // Case file driver
  ////////////////////////////////

  initial begin
    int fd;
    int n;
    int i;
    int beats;
    int err_beat;
    int dest;
    bit took;
    string cmd;
    string rest;
    logic [31:0] addr;
    logic [31:0] data;
    logic [63:0] word;
    eth_stream_pkg::axis_beat_t pkt[$];
    eth_stream_pkg::axis_beat_t b;

    reset         = 1'b1;
    i_reg_wr_req  = 1'b0;
    i_reg_wr_addr = '0;
    i_reg_wr_data = '0;
    i_reg_rd_req  = 1'b0;
    i_reg_rd_addr = '0;
    i_rx_beat     = '0;
    i_rx_valid    = 1'b0;
    fd = $fopen("testbench/switch_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/switch_cases.txt");
      drv_errors++;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    while (fd != 0 && $fscanf(fd, " %s", cmd) == 1) begin
      if (cmd == "#") begin
        n = $fgets(rest, fd);
      end else if (cmd == "W" || cmd == "R" || cmd == "N") begin
        tests++;
        limit += 20;
        if (cmd == "W") begin
          n = $fscanf(fd, " %h %h", addr, data);
          wait_drained();
          reg_write(addr, data);
        end else if (cmd == "R") begin
          n = $fscanf(fd, " %h %h", addr, data);
          reg_read(addr, data, 1'b1);
        end else begin
          n = $fscanf(fd, " %h", addr);
          reg_read(addr, '0, 1'b0);
        end
      end else if (cmd == "P") begin
        n = $fscanf(fd, " %d %d %d", beats, err_beat, dest);
        tests++;
        limit += 20 * beats;
        pkt.delete();
        for (i = 0; i < beats; i++) begin
          n = $fscanf(fd, " %h", word);
          b.data = word;
          b.user = '0;
          b.user[`ETH_ERR_BIT] = (i + 1 == err_beat);
          b.last = (i == beats - 1);
          pkt.push_back(b);
          if (dest == 1) begin
            vita_q.push_back(b);
          end else if (dest == 2) begin
            cpu_q.push_back(b);
          end
        end
        if (dest == 1) begin
          vita_ids.push_back(tests);
        end else if (dest == 2) begin
          cpu_ids.push_back(tests);
        end
        // Each beat is held until the gate takes it
        @(posedge clk);
        for (i = 0; i < beats; i++) begin
          i_rx_valid <= 1'b1;
          i_rx_beat  <= pkt[i];
          took = 1'b0;
          while (!took) begin
            @(negedge clk);
            took = o_rx_ready;
            @(posedge clk);
          end
        end
        i_rx_valid <= 1'b0;
        if (dest == 0) begin
          $display("test %0d: packet sent, no output expected", tests);
        end
      end else begin
        $display("Unknown command %s in the cases file", cmd);
        drv_errors++;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    wait_drained();

    $display("tests %0d, errors %0d", tests, drv_errors + mon_errors);
    if (drv_errors + mon_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== testbench/switch_cases.txt ====
# W addr data | R addr expected | N addr (read that gets no response)
# P beats err dest, then one hex word per beat; err is the errored beat (0 none), dest 0 drop 1 VITA 2 CPU
R 0000 2f16c52f
R 0004 00000080
R 1000 c0a80a02
R 1004 c002c001
N 0008
P 3 0 1
123400802f16c52f
0000c001c0a80a02
deadbeefcafef00d
P 2 0 2
0000ffffffffffff
0000c001c0a80a63
P 2 1 0
000000802f16c52f
0000c002c0a80a02
P 2 0 0
0000001122334455
0000c001c0a80a02
P 2 0 1
000000802f16c52f
7777c002c0a80a02
W 1010 000000b1
W 1014 abcd0200
W 1018 0a000001
W 101c 13891388
W 1020 ffffffff
R 1014 00000200
R 101c 13891388
R 1020 00000001
P 3 0 1
00000200000000b1
555513880a000001
0123456789abcdef
P 2 0 0
000000802f16c52f
0000c001c0a80a02
P 2 0 2
00000200000000b1
000020000a000001

// ==== project.f ====
+incdir+common
common/eth_stream_pkg.sv
common/eth_regs_pkg.sv
hdl/switch_regs.sv
packet_gate/packet_gate.sv
eth_dispatch/eth_dispatch.sv
hdl/eth_switch.sv
testbench/tb_eth_switch.sv

// ==== Makefile ====
# Verilator flow for the Ethernet receive switch

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --timescale 1ns/10ps -f project.f \
		--top-module tb_eth_switch -o tb_eth_switch
	./obj_dir/tb_eth_switch | tee sim.log
	@if grep -q "sim failed" sim.log; then echo "Testbench reported failure"; exit 1; fi
	@grep -q "sim passed" sim.log || (echo "No result in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
